// ==== Bender.yml ====
package:
  name: data_path

sources:
  - include_dirs:
      - design
    files:
      - design/cpu_pkg.sv
      - design/memIf.sv
      - design/regFile.sv
      - design/aluUnit.sv
      - design/memUnit.sv
      - design/dataPath.sv
  - target: test
    include_dirs:
      - design
    files:
      - dv/dataPathAssertions.sv
      - dv/dataPathTb.sv

// ==== design/aluUnit.sv ====
// Operands must hold for the request cycle; only ADD and MUL treat operands as signed
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module aluUnit (
   input  logic                  Clock,
   input  logic                  rst,
   input  cpu_pkg::aluOpT        opSelect,
   input  logic [`WORD_W-1:0]    y,
   input  logic [`WORD_W-1:0]    b,
   input  logic                  aluReq,
   output logic                  aluAck,
   output logic [2*`WORD_W-1:0]  result
);
   import cpu_pkg::*;

   localparam int CNT_W = $clog2(`MUL_STEPS + 1);
   localparam int SH_W = $clog2(`WORD_W);

   typedef enum logic [1:0] {IDLE, MULT, DONE} stateT;

   stateT                 state;
   logic [2*`WORD_W-1:0]  acc;
   logic [2*`WORD_W-1:0]  mcand;
   logic [`WORD_W-1:0]    mplier;
   logic [CNT_W-1:0]      count;
   logic [2*`WORD_W-1:0]  yExt;
   logic [2*`WORD_W-1:0]  bExt;
   logic [2*`WORD_W-1:0]  quick;
   logic [2*`WORD_W-1:0]  addend;

   assign yExt = {{`WORD_W{y[`WORD_W-1]}}, y};
   assign bExt = {{`WORD_W{b[`WORD_W-1]}}, b};

   // Single-cycle operations
   always_comb begin
      quick = '0;
      case (opSelect)
         ADD: quick = yExt + bExt;
         SUB: quick = {{`WORD_W{1'b0}}, y - b};
         AND: quick = {{`WORD_W{1'b0}}, y & b};
         OR:  quick = {{`WORD_W{1'b0}}, y | b};
         SHL: quick = {{`WORD_W{1'b0}}, y << b[SH_W-1:0]};
         SHR: quick = {{`WORD_W{1'b0}}, y >> b[SH_W-1:0]};
         default: quick = '0;
      endcase
   end

   assign addend = mplier[0] ? mcand : '0;

   always_ff @(posedge Clock) begin
      if (rst) begin
         state  <= IDLE;
         aluAck <= 1'b0;
         acc    <= '0;
         mcand  <= '0;
         mplier <= '0;
         count  <= '0;
      end else begin
         case (state)
            IDLE: begin
               if (aluReq && opSelect == MUL) begin
                  // First partial product straight from the operands
                  acc    <= b[0] ? yExt : '0;
                  mcand  <= yExt << 1;
                  mplier <= b >> 1;
                  count  <= CNT_W'(1);
                  state  <= MULT;
               end else if (aluReq) begin
                  acc    <= quick;
                  aluAck <= 1'b1;
                  state  <= DONE;
               end
            end
            MULT: begin
               if (count == CNT_W'(`MUL_STEPS)) begin
                  aluAck <= 1'b1;
                  state  <= DONE;
               end else begin
                  // Sign bit of the multiplier carries negative weight
                  if (count == CNT_W'(`MUL_STEPS - 1)) begin
                     acc <= acc - addend;
                  end else begin
                     acc <= acc + addend;
                  end
                  mcand  <= mcand << 1;
                  mplier <= mplier >> 1;
                  count  <= count + 1'b1;
               end
            end
            DONE: begin
               if (!aluReq) begin
                  aluAck <= 1'b0;
                  state  <= IDLE;
               end
            end
            default: state <= IDLE;
         endcase
      end
   end

   // Idle passes the live result so Z can load in the request cycle
   assign result = (state == IDLE) ? quick : acc;

endmodule

`default_nettype wire

// ==== design/cpu_macros.svh ====
// MEM_DEPTH must stay a power of two since memory takes only the low address bits of MAR
`ifndef CPU_MACROS_SVH
`define CPU_MACROS_SVH

// Width of the bus and of every storage element
`define WORD_W 32

// Register file entries, addressed by 4-bit instruction fields
`define NUM_REGS 16
`define REG_AW ($clog2(`NUM_REGS))

// Word-addressed memory behind MAR/MDR
`define MEM_DEPTH 512
`define MEM_AW ($clog2(`MEM_DEPTH))

// Shift-add multiplier, one iteration per multiplier bit
`define MUL_STEPS 32

`endif

// ==== design/cpu_pkg.sv ====
// Instruction layout is fixed at 32 bits; opcode values are not decoded in hardware
`default_nettype none

package cpu_pkg;

   // ALU operation select, 5 bits wide like the opSelect strobe field
   typedef enum logic [4:0] {
      ADD = 5'b00100,
      SUB = 5'b00101,
      AND = 5'b00110,
      OR  = 5'b00111,
      SHL = 5'b01000,
      SHR = 5'b01001,
      MUL = 5'b01110
   } aluOpT;

   // Three-register form
   typedef struct packed {
      logic [4:0]  opcode;
      logic [3:0]  ra;
      logic [3:0]  rb;
      logic [3:0]  rc;
      logic [14:0] spare;
   } irRegT;

   // Immediate and branch form; c2 overlays the low bits of rb
   typedef struct packed {
      logic [4:0]  opcode;
      logic [3:0]  ra;
      logic [1:0]  rbHi;
      logic [1:0]  c2;
      logic [18:0] imm;
   } irImmT;

   typedef union packed {
      irRegT r;
      irImmT i;
   } irFieldsT;

   // Who drives the shared bus in the current step
   typedef enum logic [3:0] {
      BUS_NONE,
      BUS_TB,
      BUS_RF,
      BUS_PC,
      BUS_IR,
      BUS_Y,
      BUS_ZLO,
      BUS_ZHI,
      BUS_MAR,
      BUS_HI,
      BUS_LO,
      BUS_IMM,
      BUS_INPORT,
      BUS_MDR
   } busSrcT;

endpackage

`default_nettype wire

// ==== design/dataPath.sv ====
// Control comes from outside; at most one out-strobe or tbIn may be high in any cycle
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module dataPath (
   input  logic                Clock,
   input  logic                rst,
   // Bus out-strobes
   input  logic                pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut, rhiOut,
   input  logic                rloOut, immOut, inportOut, mdrOut, rfOut, rout, baOut,
   // Register in-strobes
   input  logic                pcIn, irIn, ryIn, rzIn, marIn, rhiIn, rloIn, mdrIn,
   input  logic                rfIn, rin, conffIn, outportIn, incPc,
   // Register file addressing
   input  logic                gra, grb, grc,
   input  logic [`REG_AW-1:0]  rfSelect,
   // Direct bus drive from the sequencer
   input  logic                tbIn,
   input  logic [`WORD_W-1:0]  busInTb,
   // ALU handshake
   input  logic [4:0]          opSelect,
   input  logic                aluReq,
   output logic                aluAck,
   // Memory handshake
   input  logic                memReq, memRead, memWrite,
   output logic                memAck,
   output logic                branch,
   // Ports
   input  logic                deviceStrobe,
   input  logic [`WORD_W-1:0]  deviceIn,
   output logic [`WORD_W-1:0]  deviceOut
);
   import cpu_pkg::*;

   busSrcT                busSel;
   logic [`WORD_W-1:0]    busVal;
   logic [`WORD_W-1:0]    pc;
   irFieldsT              ir;
   logic [`WORD_W-1:0]    y;
   logic [2*`WORD_W-1:0]  z;
   logic [`WORD_W-1:0]    mar;
   logic [`WORD_W-1:0]    mdr;
   logic [`WORD_W-1:0]    hi;
   logic [`WORD_W-1:0]    lo;
   logic [`WORD_W-1:0]    inport;
   logic [`WORD_W-1:0]    rfData;
   logic [`WORD_W-1:0]    immExt;
   logic [2*`WORD_W-1:0]  aluResult;
   logic                  condMet;

   memIf memBus ();

   regFile rf0 (
      .Clock, .rst, .ir, .gra, .grb, .grc, .rin, .rout, .baOut, .rfIn, .rfOut, .rfSelect,
      .busIn (busVal),
      .regOut (rfData)
   );

   aluUnit alu0 (
      .Clock, .rst,
      .opSelect (aluOpT'(opSelect)),
      .y, .b (busVal), .aluReq, .aluAck,
      .result (aluResult)
   );

   memUnit mem0 (.Clock, .rst, .mem (memBus));

   assign memBus.addr   = mar[`MEM_AW-1:0];
   assign memBus.wrData = mdr;
   assign memBus.read   = memRead;
   assign memBus.write  = memWrite;
   assign memBus.req    = memReq;
   assign memAck        = memBus.ack;

   assign immExt = {{(`WORD_W - 19){ir.i.imm[18]}}, ir.i.imm};

   // Strobe to source encoding
   always_comb begin
      busSel = BUS_NONE;
      if (tbIn) busSel = BUS_TB;
      else if (rfOut || rout || baOut) busSel = BUS_RF;
      else if (pcOut) busSel = BUS_PC;
      else if (irOut) busSel = BUS_IR;
      else if (ryOut) busSel = BUS_Y;
      else if (rzLoOut) busSel = BUS_ZLO;
      else if (rzHiOut) busSel = BUS_ZHI;
      else if (marOut) busSel = BUS_MAR;
      else if (rhiOut) busSel = BUS_HI;
      else if (rloOut) busSel = BUS_LO;
      else if (immOut) busSel = BUS_IMM;
      else if (inportOut) busSel = BUS_INPORT;
      else if (mdrOut) busSel = BUS_MDR;
   end

   always_comb begin
      case (busSel)
         BUS_TB:     busVal = busInTb;
         BUS_RF:     busVal = rfData;
         BUS_PC:     busVal = pc;
         BUS_IR:     busVal = ir;
         BUS_Y:      busVal = y;
         BUS_ZLO:    busVal = z[`WORD_W-1:0];
         BUS_ZHI:    busVal = z[2*`WORD_W-1:`WORD_W];
         BUS_MAR:    busVal = mar;
         BUS_HI:     busVal = hi;
         BUS_LO:     busVal = lo;
         BUS_IMM:    busVal = immExt;
         BUS_INPORT: busVal = inport;
         BUS_MDR:    busVal = mdr;
         default:    busVal = '0;
      endcase
   end

   // Branch test; positive means greater than zero
   always_comb begin
      case (ir.i.c2)
         2'd0:    condMet = (busVal == '0);
         2'd1:    condMet = (busVal != '0);
         2'd2:    condMet = !busVal[`WORD_W-1] && (busVal != '0);
         default: condMet = busVal[`WORD_W-1];
      endcase
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         pc        <= '0;
         ir        <= '0;
         y         <= '0;
         z         <= '0;
         mar       <= '0;
         mdr       <= '0;
         hi        <= '0;
         lo        <= '0;
         inport    <= '0;
         deviceOut <= '0;
         branch    <= 1'b0;
      end else begin
         if (pcIn) pc <= busVal;
         else if (incPc) pc <= pc + 1'b1;
         if (irIn) ir <= irFieldsT'(busVal);
         if (ryIn) y <= busVal;
         if (rzIn) z <= aluResult;
         if (marIn) mar <= busVal;
         // Read data wins while the memory acknowledges a read
         if (mdrIn) mdr <= (memBus.ack && memRead) ? memBus.rdData : busVal;
         if (rhiIn) hi <= busVal;
         if (rloIn) lo <= busVal;
         if (deviceStrobe) inport <= deviceIn;
         if (outportIn) deviceOut <= busVal;
         if (conffIn) branch <= condMet;
      end
   end

endmodule

`default_nettype wire

// ==== design/memIf.sv ====
// Four-phase req/ack; requester must hold addr, data, read and write stable until ack
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

interface memIf;

   // Word address, taken from MAR
   logic [`MEM_AW-1:0] addr;
   logic [`WORD_W-1:0] wrData;
   logic [`WORD_W-1:0] rdData;

   // Exactly one of read or write with each request
   logic read;
   logic write;

   // Handshake pair
   logic req;
   logic ack;

   modport dp (
      output addr,
      output wrData,
      output read,
      output write,
      output req,
      input  rdData,
      input  ack
   );

   modport memory (
      input  addr,
      input  wrData,
      input  read,
      input  write,
      input  req,
      output rdData,
      output ack
   );

endinterface

`default_nettype wire

// ==== design/memUnit.sv ====
// Contents are undefined after reset; a request dropped before ack restarts the access
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module memUnit (
   input logic  Clock,
   input logic  rst,
   memIf.memory mem
);

   localparam int ACCESS_CYCLES = 2;
   localparam int CNT_W = $clog2(ACCESS_CYCLES);

   logic [`WORD_W-1:0] ram [`MEM_DEPTH];
   logic [CNT_W-1:0]   cnt;
   logic               lastCycle;

   // Transfer happens on the final counted cycle, together with ack
   assign lastCycle = mem.req && !mem.ack && (cnt == CNT_W'(ACCESS_CYCLES - 1));

   always_ff @(posedge Clock) begin
      if (rst) begin
         cnt     <= '0;
         mem.ack <= 1'b0;
      end else if (mem.ack) begin
         // Hold ack until the requester lets go
         if (!mem.req) begin
            mem.ack <= 1'b0;
         end
      end else if (lastCycle) begin
         cnt     <= '0;
         mem.ack <= 1'b1;
      end else if (mem.req) begin
         cnt <= cnt + 1'b1;
      end else begin
         cnt <= '0;
      end
   end

   // Array and read data
   always_ff @(posedge Clock) begin
      if (lastCycle) begin
         if (mem.write) begin
            ram[mem.addr] <= mem.wrData;
         end
         if (mem.read) begin
            mem.rdData <= ram[mem.addr];
         end
      end
   end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
// Only one of gra, grb, grc may be set; R0 is a normal register except under baOut
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module regFile (
   input  logic                Clock,
   input  logic                rst,
   input  cpu_pkg::irFieldsT   ir,
   input  logic                gra,
   input  logic                grb,
   input  logic                grc,
   input  logic                rin,
   input  logic                rout,
   input  logic                baOut,
   input  logic                rfIn,
   input  logic                rfOut,
   input  logic [`REG_AW-1:0]  rfSelect,
   input  logic [`WORD_W-1:0]  busIn,
   output logic [`WORD_W-1:0]  regOut
);

   logic [`WORD_W-1:0] regs [`NUM_REGS];
   logic [`REG_AW-1:0] regSel;
   logic               useIr;

   // IR fields pick the register for Rin/Rout/BAout steps
   assign useIr = rin | rout | baOut;

   always_comb begin
      regSel = rfSelect;
      if (useIr) begin
         if (gra) begin
            regSel = ir.r.ra;
         end else if (grb) begin
            regSel = ir.r.rb;
         end else if (grc) begin
            regSel = ir.r.rc;
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (rst) begin
         for (int i = 0; i < `NUM_REGS; i++) begin
            regs[i] <= '0;
         end
      end else if (rin || rfIn) begin
         regs[regSel] <= busIn;
      end
   end

   // Base-address path sees R0 as zero
   always_comb begin
      regOut = '0;
      if (rfOut || rout || baOut) begin
         if (!(baOut && regSel == '0)) begin
            regOut = regs[regSel];
         end
      end
   end

endmodule

`default_nettype wire

// ==== dv/dataPathAssertions.sv ====
// Bound into dataPath; expects the sequencer to hold each request until its ack rises
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module dataPathAssertions (
   input logic                Clock,
   input logic                rst,
   input logic                aluReq,
   input logic                aluAck,
   input logic                memReq,
   input logic                memAck,
   input logic                branch,
   input logic [`WORD_W-1:0]  deviceOut,
   input cpu_pkg::busSrcT     busSel,
   input logic                tbIn, pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut,
   input logic                rhiOut, rloOut, immOut, inportOut, mdrOut, rfOut, rout, baOut,
   input logic                pcIn, irIn, ryIn, marIn, rhiIn, rloIn, rfIn, rin,
   input logic                conffIn, outportIn
);
   import cpu_pkg::*;

   int          failCount = 0;
   logic [14:0] outStrobes;
   logic        busLoad;

   assign outStrobes = {tbIn, pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut, rhiOut, rloOut,
                        immOut, inportOut, mdrOut, rfOut, rout, baOut};

   // Registers that take their next value from the bus
   assign busLoad = pcIn | irIn | ryIn | marIn | rhiIn | rloIn | rfIn | rin
                    | conffIn | outportIn;

   // Acks only rise in answer to a request seen on the edge before
   aluAckNeedsReq: assert property (@(posedge Clock) disable iff (rst)
      $rose(aluAck) |-> $past(aluReq))
      else begin
         $error("ALU ack rose without a request");
         failCount++;
      end
   memAckNeedsReq: assert property (@(posedge Clock) disable iff (rst)
      $rose(memAck) |-> $past(memReq))
      else begin
         $error("memory ack rose without a request");
         failCount++;
      end

   // Requests only fall once acknowledged
   aluReqHeld: assert property (@(posedge Clock) disable iff (rst) $fell(aluReq) |-> aluAck)
      else begin
         $error("ALU request dropped before its ack");
         failCount++;
      end
   memReqHeld: assert property (@(posedge Clock) disable iff (rst) $fell(memReq) |-> memAck)
      else begin
         $error("memory request dropped before its ack");
         failCount++;
      end

   // At most one bus driver
   singleDriver: assert property (@(posedge Clock) disable iff (rst)
      $onehot0(outStrobes) && !$isunknown(outStrobes))
      else begin
         $error("more than one bus driver or an unknown out-strobe");
         failCount++;
      end

   // A register loading from the bus needs a driver on it
   busDriven: assert property (@(posedge Clock) disable iff (rst)
      busLoad |-> busSel != BUS_NONE)
      else begin
         $error("register loaded from an undriven bus");
         failCount++;
      end

   // Synchronous reset clears the visible outputs
   resetClears: assert property (@(posedge Clock)
      rst |=> (!aluAck && !memAck && !branch && deviceOut == '0))
      else begin
         $error("outputs not cleared by reset");
         failCount++;
      end

endmodule

`default_nettype wire

// ==== dv/dataPathTb.sv ====
// Testbench acts as the control unit; one strobe set per cycle, driven on the falling edge
`default_nettype none
`timescale 1ns/1ps
`include "cpu_macros.svh"

module dataPathTb;
   import cpu_pkg::*;

   localparam int ACK_LIMIT = 100;

   logic Clock, rst;
   logic pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut, rhiOut;
   logic rloOut, immOut, inportOut, mdrOut, rfOut, rout, baOut;
   logic pcIn, irIn, ryIn, rzIn, marIn, rhiIn, rloIn, mdrIn;
   logic rfIn, rin, conffIn, outportIn, incPc;
   logic gra, grb, grc;
   logic [3:0] rfSelect;
   logic tbIn;
   logic [31:0] busInTb;
   logic [4:0] opSelect;
   logic aluReq, aluAck;
   logic memReq, memRead, memWrite, memAck;
   logic branch;
   logic deviceStrobe;
   logic [31:0] deviceIn, deviceOut;

   logic [31:0] lcgState = 32'h2f35;
   logic [31:0] regModel [16];
   logic [31:0] memModel [`MEM_DEPTH];
   int checks = 0;
   int errors = 0;
   int timeouts = 0;

   dataPath dut0 (.*);

   bind dataPath dataPathAssertions asrt0 (
      .Clock, .rst, .aluReq, .aluAck, .memReq, .memAck, .branch, .deviceOut, .busSel,
      .tbIn, .pcOut, .irOut, .ryOut, .rzLoOut, .rzHiOut, .marOut, .rhiOut, .rloOut,
      .immOut, .inportOut, .mdrOut, .rfOut, .rout, .baOut,
      .pcIn, .irIn, .ryIn, .marIn, .rhiIn, .rloIn, .rfIn, .rin, .conffIn, .outportIn
   );

   initial begin
      Clock = 1'b0;
      forever #20 Clock = ~Clock;
   end

   // Hard stop in case a wait loop is never reached
   initial begin
      #1_000_000;
      $display("Simulation time limit reached before the test finished");
      $display("*** TEST FAILED ***");
      $finish;
   end

   function automatic logic [31:0] nextRand();
      lcgState = lcgState * 32'd1664525 + 32'd1013904223;
      return lcgState;
   endfunction

   // Reference ALU built from the operation rules
   function automatic logic [63:0] aluModel(aluOpT op, logic [31:0] a, logic [31:0] b);
      longint prod;
      prod = longint'($signed(a)) * longint'($signed(b));
      case (op)
         ADD:     return {32'h0, a + b};
         SUB:     return {32'h0, a - b};
         AND:     return {32'h0, a & b};
         OR:      return {32'h0, a | b};
         SHL:     return {32'h0, a << b[4:0]};
         SHR:     return {32'h0, a >> b[4:0]};
         default: return prod;
      endcase
   endfunction

   task automatic clearStrobes();
      {pcOut, irOut, ryOut, rzLoOut, rzHiOut, marOut, rhiOut} = '0;
      {rloOut, immOut, inportOut, mdrOut, rfOut, rout, baOut} = '0;
      {pcIn, irIn, ryIn, rzIn, marIn, rhiIn, rloIn, mdrIn} = '0;
      {rfIn, rin, conffIn, outportIn, incPc, gra, grb, grc} = '0;
      {tbIn, deviceStrobe} = '0;
   endtask

   // Strobes set before the call act on the next rising edge
   task automatic tick();
      @(posedge Clock);
      @(negedge Clock);
      clearStrobes();
   endtask

   task automatic waitAck(input bit isMem, input bit level);
      int n;
      n = 0;
      while ((isMem ? memAck : aluAck) !== level && n < ACK_LIMIT) begin
         @(negedge Clock);
         n++;
      end
      assert ((isMem ? memAck : aluAck) === level)
      else begin
         $display("Timeout: %s ack did not reach %0b", isMem ? "memory" : "ALU", level);
         timeouts++;
      end
   endtask

   task automatic checkEq(input string name, input logic [31:0] exp, input logic [31:0] act);
      checks++;
      assert (act === exp)
      else begin
         $display("ERR %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   task automatic loadIr(input logic [31:0] word);
      tbIn = 1'b1;
      busInTb = word;
      irIn = 1'b1;
      tick();
   endtask

   task automatic writeReg(input logic [3:0] idx, input logic [31:0] val);
      tbIn = 1'b1;
      busInTb = val;
      rfIn = 1'b1;
      rfSelect = idx;
      tick();
      regModel[idx] = val;
   endtask

   // Caller puts the second operand on the bus in the same step
   task automatic aluRequest(input aluOpT op);
      opSelect = op;
      aluReq = 1'b1;
      tick();
      waitAck(1'b0, 1'b1);
      rzIn = 1'b1;
      tick();
      aluReq = 1'b0;
      waitAck(1'b0, 1'b0);
   endtask

   task automatic memAccess(input bit isWrite);
      memReq = 1'b1;
      memWrite = isWrite;
      memRead = !isWrite;
      waitAck(1'b1, 1'b1);
      if (!isWrite) begin
         mdrIn = 1'b1;
         tick();
      end
      memReq = 1'b0;
      waitAck(1'b1, 1'b0);
      memWrite = 1'b0;
      memRead = 1'b0;
   endtask

   initial begin
      aluOpT ops [7];
      logic [31:0] a, b, val, base, word, effAddr;
      logic [63:0] expZ;
      logic [3:0] idx, ra, rb;
      logic [18:0] imm;
      logic [`MEM_AW-1:0] addr;
      logic expBr;

      ops = '{ADD, SUB, AND, OR, SHL, SHR, MUL};
      clearStrobes();
      rfSelect = '0;
      busInTb = '0;
      opSelect = '0;
      {aluReq, memReq, memRead, memWrite} = '0;
      deviceIn = '0;
      for (int i = 0; i < 16; i++) regModel[i] = '0;
      rst = 1'b1;
      repeat (3) @(posedge Clock);
      @(negedge Clock);
      rst = 1'b0;

      // Reset values
      checkEq("reset deviceOut", 32'h0, deviceOut);
      checkEq("reset flags", 32'h0, {29'h0, branch, aluAck, memAck});

      // Register write and read back by number or by IR field
      for (int i = 0; i < 10; i++) begin
         idx = 4'(nextRand() % 16);
         writeReg(idx, nextRand());
         if (i % 2 == 0) begin
            rfOut = 1'b1;
            rfSelect = idx;
         end else begin
            loadIr({5'h0, idx, 23'h0});
            rout = 1'b1;
            gra = 1'b1;
            // Direct select points elsewhere so only the IR field can pick idx
            rfSelect = ~idx;
         end
         outportIn = 1'b1;
         tick();
         checkEq("register readback", regModel[idx], deviceOut);
      end

      // Every ALU operation twice
      for (int i = 0; i < 14; i++) begin
         a = nextRand();
         b = nextRand();
         tbIn = 1'b1;
         busInTb = a;
         ryIn = 1'b1;
         tick();
         tbIn = 1'b1;
         busInTb = b;
         aluRequest(ops[i % 7]);
         expZ = aluModel(ops[i % 7], a, b);
         rzLoOut = 1'b1;
         outportIn = 1'b1;
         tick();
         checkEq({"alu low ", ops[i % 7].name()}, expZ[31:0], deviceOut);
         if (ops[i % 7] == MUL) begin
            rzHiOut = 1'b1;
            outportIn = 1'b1;
            tick();
            checkEq("alu high MUL", expZ[63:32], deviceOut);
         end
      end

      // Store with offset then load from the address the model computes
      for (int i = 0; i < 5; i++) begin
         ra = 4'(nextRand() % 16);
         rb = (i == 0) ? 4'd0 : 4'(nextRand() % 16);
         imm = 19'(nextRand());
         writeReg(rb, nextRand() % 1024);
         writeReg(ra, nextRand());
         base = (rb == 0) ? 32'h0 : regModel[rb];
         effAddr = base + {{13{imm[18]}}, imm};
         addr = effAddr[`MEM_AW-1:0];
         loadIr({5'h0, ra, rb, imm});
         baOut = 1'b1;
         grb = 1'b1;
         ryIn = 1'b1;
         tick();
         immOut = 1'b1;
         aluRequest(ADD);
         rzLoOut = 1'b1;
         marIn = 1'b1;
         tick();
         rout = 1'b1;
         gra = 1'b1;
         mdrIn = 1'b1;
         tick();
         memAccess(1'b1);
         memModel[addr] = regModel[ra];
         // Load goes through the model address
         tbIn = 1'b1;
         busInTb = 32'(addr);
         marIn = 1'b1;
         tick();
         // Overwrite MDR so the load has to fetch
         tbIn = 1'b1;
         busInTb = ~regModel[ra];
         mdrIn = 1'b1;
         tick();
         memAccess(1'b0);
         mdrOut = 1'b1;
         outportIn = 1'b1;
         tick();
         checkEq("store then load", memModel[addr], deviceOut);
      end

      // Condition flip-flop for each c2
      for (int i = 0; i < 16; i++) begin
         val = (i < 4) ? 32'h0 : nextRand();
         word = {11'h0, 2'(i % 4), 19'h0};
         loadIr(word);
         tbIn = 1'b1;
         busInTb = val;
         conffIn = 1'b1;
         tick();
         case (i % 4)
            0: expBr = (val == 0);
            1: expBr = (val != 0);
            2: expBr = ($signed(val) > 0);
            default: expBr = ($signed(val) < 0);
         endcase
         checkEq("branch condition", {31'h0, expBr}, {31'h0, branch});
      end

      // Input port through a register to the output port
      for (int i = 0; i < 4; i++) begin
         val = nextRand();
         idx = 4'(nextRand() % 16);
         deviceIn = val;
         deviceStrobe = 1'b1;
         tick();
         inportOut = 1'b1;
         rfIn = 1'b1;
         rfSelect = idx;
         tick();
         rfOut = 1'b1;
         rfSelect = idx;
         outportIn = 1'b1;
         tick();
         checkEq("port loop", val, deviceOut);
      end

      $display("Checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
               checks, errors, timeouts, dut0.asrt0.failCount);
      if (errors == 0 && timeouts == 0 && dut0.asrt0.failCount == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== flist.f ====
+incdir+design
design/cpu_pkg.sv
design/memIf.sv
design/regFile.sv
design/aluUnit.sv
design/memUnit.sv
design/dataPath.sv
dv/dataPathAssertions.sv
dv/dataPathTb.sv
